// File: rtl/mfPkg.sv
//##############################
// Matched filter package.
// Widths, tap counts, fixed Hilbert weights, APB register map
// and the control state encoding shared by the pulse-compression
// matched filter.
//##############################

package mfPkg;

	// Real input sample width.
	localparam int DataWidth = 12;

	// Width of each part of the analytic (Hilbert) stream.
	localparam int HtWidth = 14;

	// Hilbert filter shape. The centre tap sits HtDelay samples back.
	localparam int HtTaps = 7;
	localparam int HtDelay = 3;
	localparam int HtShift = 10;

	// Nonzero Hilbert weights, 2/pi and 2/(3*pi) scaled by 1024.
	// Odd offsets only; the older side is positive.
	localparam int HtCoeff1 = 652;
	localparam int HtCoeff3 = 217;

	// Matched-filter coefficients and accumulator.
	localparam int CoeffWidth = 12;
	localparam int FirTaps = 8;
	// Wide enough for the full eight-tap complex sum.
	localparam int AccWidth = 32;

	// APB register map.
	// Control register: bit 0 starts a run, bit 1 aborts it.
	localparam logic [31:0] CtrlAddr = 32'h00;
	// Status register: state in 1:0, done flag in bit 2.
	localparam logic [31:0] StatusAddr = 32'h04;
	// Number of outputs produced by the last run.
	localparam logic [31:0] CountAddr = 32'h08;
	// Coefficient k lives at CoeffBase + 4k, real in 11:0, imaginary in 27:16.
	localparam logic [31:0] CoeffBase = 32'h40;

	// Run sequencing states. The encoding is visible in the status register.
	typedef enum logic [1:0] {
		Idle = 2'd0,
		Run = 2'd1,
		Flush = 2'd2,
		Done = 2'd3
	} mfState_t;

endpackage

// File: rtl/sampleIf.sv
//##############################
// Complex sample stream.
// Carries one analytic sample per valid cycle between the
// Hilbert stage and the complex FIR. There is no stall.
//##############################

`timescale 1ns/1ps

interface sampleIf;
	import mfPkg::*;

	// A sample moves on every edge where valid is high.
	logic valid;
	logic signed [HtWidth-1:0] re;
	logic signed [HtWidth-1:0] im;
	// Marks the final sample of a run.
	logic last;

	modport source (output valid, output re, output im, output last);

	modport sink (input valid, input re, input im, input last);

endinterface

// File: rtl/mfControl.sv
//##############################
// Matched filter control.
// APB slave holding the coefficient store and the control,
// status and count registers. Its FSM gates the input stream,
// injects the Hilbert flush samples and reports completion.
//##############################

`timescale 1ns/1ps

module mfControl (
	input logic clock,
	input logic rstN,
	input logic [31:0] paddr,
	input logic [31:0] pwdata,
	input logic psel,
	input logic penable,
	input logic pwrite,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic signed [mfPkg::DataWidth-1:0] dataIn,
	input logic dataValid,
	input logic dataLast,
	output logic signed [mfPkg::DataWidth-1:0] htIn,
	output logic htValid,
	output logic htLast,
	output logic pipeClear,
	input logic firDone,
	output logic [mfPkg::FirTaps*mfPkg::CoeffWidth-1:0] coeffRe,
	output logic [mfPkg::FirTaps*mfPkg::CoeffWidth-1:0] coeffIm
);
	import mfPkg::*;

	mfState_t state;
	logic doneFlag;
	logic [31:0] outCount;
	logic [$clog2(HtDelay+1)-1:0] flushCnt;

	logic access;
	logic isCtrl, isStatus, isCount, isCoeff;
	logic [31:0] coeffOffset;
	logic [$clog2(FirTaps)-1:0] coeffIdx;
	logic ctrlWrite, coeffWrite, startHit, abortHit;
	logic rawValid;

	// The slave never inserts wait states.
	assign pready = 1'b1;
	assign access = psel & penable;

	// Address decode. Addresses below CoeffBase wrap to a large offset.
	assign coeffOffset = paddr - CoeffBase;
	assign coeffIdx = coeffOffset[2 +: $clog2(FirTaps)];
	assign isCtrl = (paddr == CtrlAddr);
	assign isStatus = (paddr == StatusAddr);
	assign isCount = (paddr == CountAddr);
	assign isCoeff = (coeffOffset < 32'(FirTaps * 4)) && (coeffOffset[1:0] == 2'b00);

	// Errors: unmapped address, read-only write, or a coefficient write during a run.
	assign pslverr = access & (~(isCtrl | isStatus | isCount | isCoeff)
		| (pwrite & (isStatus | isCount | (isCoeff & (state != Idle)))));

	assign ctrlWrite = access & pwrite & isCtrl;
	assign coeffWrite = access & pwrite & isCoeff & (state == Idle);
	assign startHit = ctrlWrite & pwdata[0] & (state == Idle);
	assign abortHit = ctrlWrite & pwdata[1];

	// Clearing acts on the same edge as the control write.
	assign pipeClear = startHit | abortHit;

	// Read mux for the access phase.
	always_comb begin
		prdata = '0;
		if (access && !pwrite) begin
			if (isStatus)
				prdata = {29'd0, doneFlag, state};
			else if (isCount)
				prdata = outCount;
			else if (isCoeff)
				prdata = {4'd0, coeffIm[coeffIdx*CoeffWidth +: CoeffWidth],
					4'd0, coeffRe[coeffIdx*CoeffWidth +: CoeffWidth]};
		end
	end

	// Samples pass only in Run. Flush feeds HtDelay zeros, the last one flagged.
	assign rawValid = (state == Run) ? dataValid
		: ((state == Flush) && (flushCnt < HtDelay));
	assign htValid = rawValid & ~pipeClear;
	assign htIn = (state == Run) ? dataIn : '0;
	assign htLast = (state == Flush) && (flushCnt == HtDelay - 1);

	// Coefficient store.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			coeffRe <= '0;
			coeffIm <= '0;
		end else if (coeffWrite) begin
			coeffRe[coeffIdx*CoeffWidth +: CoeffWidth] <= pwdata[CoeffWidth-1:0];
			coeffIm[coeffIdx*CoeffWidth +: CoeffWidth] <= pwdata[16 +: CoeffWidth];
		end
	end

	// Run sequencing.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			state <= Idle;
			doneFlag <= 1'b0;
			outCount <= '0;
			flushCnt <= '0;
		end else if (abortHit) begin
			state <= Idle;
			doneFlag <= 1'b0;
		end else begin
			// Every forwarded or injected sample yields one output.
			if (htValid)
				outCount <= outCount + 1'b1;
			case (state)
				Idle: begin
					if (startHit) begin
						state <= Run;
						doneFlag <= 1'b0;
						outCount <= '0;
					end
				end
				Run: begin
					if (dataValid && dataLast) begin
						state <= Flush;
						flushCnt <= '0;
					end
				end
				Flush: begin
					if (flushCnt < HtDelay)
						flushCnt <= flushCnt + 1'b1;
					// The flagged flush sample has left the FIR.
					if (firDone)
						state <= Done;
				end
				Done: begin
					doneFlag <= 1'b1;
					state <= Idle;
				end
				default: state <= Idle;
			endcase
		end
	end

endmodule

// File: rtl/hilbertTransform.sv
//##############################
// Hilbert transform.
// Turns the real sample stream into an analytic stream with a
// 7-tap antisymmetric FIR. The real part is the centre sample,
// the imaginary part the weighted tap sum.
//##############################

`timescale 1ns/1ps

module hilbertTransform (
	input logic clock,
	input logic rstN,
	input logic clear,
	input logic signed [mfPkg::DataWidth-1:0] inData,
	input logic inValid,
	input logic inLast,
	sampleIf.source out
);
	import mfPkg::*;

	// Stored history. Entry 0 is the most recent accepted sample.
	logic signed [DataWidth-1:0] history [HtTaps-1];
	// Full tap window with the incoming sample in front.
	logic signed [DataWidth-1:0] window [HtTaps];
	logic signed [31:0] imagSum;
	logic signed [31:0] imagShift;

	always_comb begin
		window[0] = inData;
		for (int i = 1; i < HtTaps; i++)
			window[i] = history[i-1];
	end

	// Odd offsets around the centre. Older samples carry the positive weight.
	assign imagSum = HtCoeff1 * (window[HtDelay+1] - window[HtDelay-1])
		+ HtCoeff3 * (window[HtDelay+3] - window[HtDelay-3]);
	assign imagShift = imagSum >>> HtShift;

	// The history only moves when a sample arrives.
	always_ff @(posedge clock) begin
		if (!rstN || clear) begin
			for (int i = 0; i < HtTaps - 1; i++)
				history[i] <= '0;
		end else if (inValid) begin
			for (int i = 0; i < HtTaps - 1; i++)
				history[i] <= window[i];
		end
	end

	// Output register, one cycle behind the input.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			out.valid <= 1'b0;
			out.last <= 1'b0;
			out.re <= '0;
			out.im <= '0;
		end else if (clear) begin
			out.valid <= 1'b0;
			out.last <= 1'b0;
		end else begin
			out.valid <= inValid;
			out.last <= inValid & inLast;
			if (inValid) begin
				// Centre sample, sign-extended.
				out.re <= HtWidth'(window[HtDelay]);
				out.im <= imagShift[HtWidth-1:0];
			end
		end
	end

endmodule

// File: rtl/complexFir.sv
//##############################
// Complex FIR.
// Convolves the analytic stream with eight complex taps.
// Stage one forms the four real products per tap, stage two
// sums them into the real and imaginary outputs.
//##############################

`timescale 1ns/1ps

module complexFir (
	input logic clock,
	input logic rstN,
	input logic clear,
	sampleIf.sink in,
	input logic [mfPkg::FirTaps*mfPkg::CoeffWidth-1:0] coeffRe,
	input logic [mfPkg::FirTaps*mfPkg::CoeffWidth-1:0] coeffIm,
	output logic signed [mfPkg::AccWidth-1:0] outRe,
	output logic signed [mfPkg::AccWidth-1:0] outIm,
	output logic outValid,
	output logic outLast
);
	import mfPkg::*;

	localparam int ProdWidth = HtWidth + CoeffWidth;

	// Stored history of the complex stream, newest in entry 0.
	logic signed [HtWidth-1:0] histRe [FirTaps-1];
	logic signed [HtWidth-1:0] histIm [FirTaps-1];
	// Tap window including the sample arriving this cycle.
	logic signed [HtWidth-1:0] winRe [FirTaps];
	logic signed [HtWidth-1:0] winIm [FirTaps];
	logic signed [CoeffWidth-1:0] cRe [FirTaps];
	logic signed [CoeffWidth-1:0] cIm [FirTaps];

	// Stage one products. With x = a + jb and c = c + jd per tap.
	logic signed [ProdWidth-1:0] prodAc [FirTaps];
	logic signed [ProdWidth-1:0] prodBd [FirTaps];
	logic signed [ProdWidth-1:0] prodAd [FirTaps];
	logic signed [ProdWidth-1:0] prodBc [FirTaps];
	logic s1Valid, s1Last;

	logic signed [AccWidth-1:0] sumRe, sumIm;

	always_comb begin
		winRe[0] = in.re;
		winIm[0] = in.im;
		for (int k = 1; k < FirTaps; k++) begin
			winRe[k] = histRe[k-1];
			winIm[k] = histIm[k-1];
		end
		for (int k = 0; k < FirTaps; k++) begin
			cRe[k] = $signed(coeffRe[k*CoeffWidth +: CoeffWidth]);
			cIm[k] = $signed(coeffIm[k*CoeffWidth +: CoeffWidth]);
		end
	end

	// Stage one: advance the history and capture the products.
	always_ff @(posedge clock) begin
		if (!rstN || clear) begin
			for (int k = 0; k < FirTaps - 1; k++) begin
				histRe[k] <= '0;
				histIm[k] <= '0;
			end
			s1Valid <= 1'b0;
			s1Last <= 1'b0;
		end else begin
			s1Valid <= in.valid;
			s1Last <= in.valid & in.last;
			if (in.valid) begin
				for (int k = 0; k < FirTaps - 1; k++) begin
					histRe[k] <= winRe[k];
					histIm[k] <= winIm[k];
				end
			end
		end
	end

	// Products are payload and only load with a valid sample.
	always_ff @(posedge clock) begin
		if (in.valid) begin
			for (int k = 0; k < FirTaps; k++) begin
				prodAc[k] <= winRe[k] * cRe[k];
				prodBd[k] <= winIm[k] * cIm[k];
				prodAd[k] <= winRe[k] * cIm[k];
				prodBc[k] <= winIm[k] * cRe[k];
			end
		end
	end

	// Real part is ac - bd, imaginary part is ad + bc.
	always_comb begin
		sumRe = '0;
		sumIm = '0;
		for (int k = 0; k < FirTaps; k++) begin
			sumRe = sumRe + prodAc[k] - prodBd[k];
			sumIm = sumIm + prodAd[k] + prodBc[k];
		end
	end

	// Stage two: register the sums.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			outRe <= '0;
			outIm <= '0;
			outValid <= 1'b0;
			outLast <= 1'b0;
		end else if (clear) begin
			outValid <= 1'b0;
			outLast <= 1'b0;
		end else begin
			outValid <= s1Valid;
			outLast <= s1Last;
			if (s1Valid) begin
				outRe <= sumRe;
				outIm <= sumIm;
			end
		end
	end

endmodule

// File: rtl/matchedFilter.sv
//##############################
// Matched filter top.
// APB-programmed complex matched filter for pulse compression.
// A real stream goes through the Hilbert stage and then the
// eight-tap complex FIR.
//##############################

`timescale 1ns/1ps

module matchedFilter (
	input logic clock,
	input logic rstN,
	input logic [31:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic signed [mfPkg::DataWidth-1:0] dataIn,
	input logic dataValid,
	input logic dataLast,
	output logic signed [mfPkg::AccWidth-1:0] mfOutRe,
	output logic signed [mfPkg::AccWidth-1:0] mfOutIm,
	output logic mfValid
);
	import mfPkg::*;

	// Gated real stream from the control block into the Hilbert stage.
	logic signed [DataWidth-1:0] htIn;
	logic htValid;
	logic htLast;
	// Start and abort both flush the pipeline.
	logic pipeClear;
	logic firDone;
	logic [FirTaps*CoeffWidth-1:0] coeffRe;
	logic [FirTaps*CoeffWidth-1:0] coeffIm;

	// Analytic stream between the Hilbert stage and the FIR.
	sampleIf htBus ();

	mfControl mfControl_i (
		.clock (clock),
		.rstN (rstN),
		.paddr (paddr),
		.pwdata (pwdata),
		.psel (psel),
		.penable (penable),
		.pwrite (pwrite),
		.prdata (prdata),
		.pready (pready),
		.pslverr (pslverr),
		.dataIn (dataIn),
		.dataValid (dataValid),
		.dataLast (dataLast),
		.htIn (htIn),
		.htValid (htValid),
		.htLast (htLast),
		.pipeClear (pipeClear),
		.firDone (firDone),
		.coeffRe (coeffRe),
		.coeffIm (coeffIm)
	);

	hilbertTransform hilbertTransform_i (
		.clock (clock),
		.rstN (rstN),
		.clear (pipeClear),
		.inData (htIn),
		.inValid (htValid),
		.inLast (htLast),
		.out (htBus.source)
	);

	// The final flagged output tells the control block the run is over.
	complexFir complexFir_i (
		.clock (clock),
		.rstN (rstN),
		.clear (pipeClear),
		.in (htBus.sink),
		.coeffRe (coeffRe),
		.coeffIm (coeffIm),
		.outRe (mfOutRe),
		.outIm (mfOutIm),
		.outValid (mfValid),
		.outLast (firDone)
	);

endmodule

// File: dv/matchedFilter_asserts.sv
//##############################
// Matched filter assertions.
// Bound to the top level. Checks output timing, APB
// ready, the reset state and a quiet idle pipeline.
//##############################

`timescale 1ns/1ps

module matchedFilterAsserts (
	input logic clock,
	input logic rstN,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic htValid,
	input logic pipeClear,
	input logic mfValid,
	input logic [1:0] state
);
	import mfPkg::*;

	// Number of assertion failures seen so far.
	int unsigned failCount = 0;

	// A sample entering the Hilbert stage leaves the FIR three edges later,
	// unless a start or abort cleared the pipeline on the way.
	sampleToOutput: assert property (@(posedge clock) disable iff (!rstN)
		($past(htValid, 3) && !$past(pipeClear, 1) && !$past(pipeClear, 2)) |-> mfValid)
		else begin
			$error("mfValid missing three cycles after an accepted sample");
			failCount++;
		end

	// Every output traces back to a sample three cycles earlier.
	outputHasSample: assert property (@(posedge clock) disable iff (!rstN)
		mfValid |-> $past(htValid, 3))
		else begin
			$error("mfValid without a sample three cycles earlier");
			failCount++;
		end

	// Zero wait states.
	apbReady: assert property (@(posedge clock) (psel && penable) |-> pready)
		else begin
			$error("pready low in an APB access phase");
			failCount++;
		end

	resetQuiet: assert property (@(posedge clock) !rstN |=> (!mfValid && !pslverr))
		else begin
			$error("mfValid or pslverr high after a reset cycle");
			failCount++;
		end

	// Once idle for three cycles, the pipeline has drained.
	idleQuiet: assert property (@(posedge clock) disable iff (!rstN)
		(state == Idle && $past(state) == Idle && $past(state, 2) == Idle) |-> !mfValid)
		else begin
			$error("mfValid while the controller is idle");
			failCount++;
		end

endmodule

bind matchedFilter matchedFilterAsserts matchedFilterAsserts_i (
	.clock (clock),
	.rstN (rstN),
	.psel (psel),
	.penable (penable),
	.pready (pready),
	.pslverr (pslverr),
	.htValid (htValid),
	.pipeClear (pipeClear),
	.mfValid (mfValid),
	.state (mfControl_i.state)
);

// File: dv/matchedFilterTb.sv
//##############################
// Matched filter testbench.
// Programs the taps over APB, streams real samples and checks
// every output against a software Hilbert and FIR model.
//##############################

`timescale 1ns/1ps

module matchedFilterTb;
	import mfPkg::*;

	logic clock, rstN;
	logic [31:0] paddr, pwdata, prdata;
	logic psel, penable, pwrite, pready, pslverr;
	logic signed [DataWidth-1:0] dataIn;
	logic dataValid, dataLast;
	logic signed [AccWidth-1:0] mfOutRe, mfOutIm;
	logic mfValid;

	int errors = 0;
	int outputs = 0;
	int cycles = 0;
	// Real input samples of the current run.
	int samples [$];
	int coefRe [FirTaps];
	int coefIm [FirTaps];
	// Expected outputs, oldest first.
	int expRe [$];
	int expIm [$];
	logic [31:0] rd;
	logic err;

	matchedFilter matchedFilter_i (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// The full test needs well under 2000 cycles.
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles == 4000) begin
			$display("Timeout: the run did not finish within 4000 clock cycles.");
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// Each output is compared with the oldest expected result at the falling edge.
	always @(negedge clock) begin
		if (rstN && mfValid) begin
			outputs++;
			if (expRe.size() == 0) begin
				$display("Unexpected output at %0t with no result pending.", $time);
				errors++;
			end else begin
				assert (mfOutRe == expRe[0]) else begin
					$display("FAILED at %0t: mfOutRe expected %0d, got %0d",
						$time, expRe[0], mfOutRe);
					errors++;
				end
				assert (mfOutIm == expIm[0]) else begin
					$display("FAILED at %0t: mfOutIm expected %0d, got %0d",
						$time, expIm[0], mfOutIm);
					errors++;
				end
				void'(expRe.pop_front());
				void'(expIm.pop_front());
			end
		end
	end

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp) else begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	// One APB transfer. Read data and the error flag come from the access phase.
	task automatic apbAccess(input logic write, input logic [31:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic slvErr);
		@(posedge clock);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clock);
		penable <= 1'b1;
		@(negedge clock);
		rdata = prdata;
		slvErr = pslverr;
		@(posedge clock);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	function automatic int randomPart();
		return $urandom % 4096 - 2048;
	endfunction

	function automatic logic [31:0] packCoeff(input int k);
		return {4'd0, 12'(coefIm[k]), 4'd0, 12'(coefRe[k])};
	endfunction

	task automatic writeCoeffs();
		for (int k = 0; k < FirTaps; k++) begin
			apbAccess(1'b1, CoeffBase + 32'(4 * k), packCoeff(k), rd, err);
			checkValue("pslverr", {31'd0, err}, 32'd0);
			apbAccess(1'b0, CoeffBase + 32'(4 * k), 32'd0, rd, err);
			checkValue("coefficient readback", rd, packCoeff(k));
		end
	endtask

	// Samples past the end of the run are the zero flush samples.
	function automatic int sampleAt(input int idx);
		return (idx < 0 || idx >= samples.size()) ? 0 : samples[idx];
	endfunction

	// Hilbert rule, then the complex convolution, one output per input.
	task automatic buildExpected(input int numIn);
		int htRe [$];
		int htIm [$];
		int tapSum, accRe, accIm;
		for (int n = 0; n < numIn; n++) begin
			htRe.push_back(sampleAt(n - HtDelay));
			tapSum = HtCoeff1 * (sampleAt(n - HtDelay - 1) - sampleAt(n - HtDelay + 1))
				+ HtCoeff3 * (sampleAt(n - HtDelay - 3) - sampleAt(n - HtDelay + 3));
			htIm.push_back(tapSum >>> HtShift);
			accRe = 0;
			accIm = 0;
			for (int k = 0; k <= n && k < FirTaps; k++) begin
				accRe += htRe[n - k] * coefRe[k] - htIm[n - k] * coefIm[k];
				accIm += htRe[n - k] * coefIm[k] + htIm[n - k] * coefRe[k];
			end
			expRe.push_back(accRe);
			expIm.push_back(accIm);
		end
	endtask

	task automatic sendSamples(input bit gaps, input bit markLast);
		for (int i = 0; i < samples.size(); i++) begin
			if (gaps && ($urandom % 4 == 0)) begin
				@(posedge clock);
				dataValid <= 1'b0;
			end
			@(posedge clock);
			dataValid <= 1'b1;
			dataIn <= 12'(samples[i]);
			dataLast <= markLast && (i == samples.size() - 1);
		end
		@(posedge clock);
		dataValid <= 1'b0;
		dataLast <= 1'b0;
	endtask

	// Polls the status register until the done flag shows up.
	task automatic waitDone(input int count);
		do
			apbAccess(1'b0, StatusAddr, 32'd0, rd, err);
		while (!rd[2]);
		checkValue("status", rd, 32'h4);
		checkValue("pending results", 32'(expRe.size()), 32'd0);
		apbAccess(1'b0, CountAddr, 32'd0, rd, err);
		checkValue("output count", rd, 32'(count));
	endtask

	task automatic randomSamples(input int num);
		samples.delete();
		for (int i = 0; i < num; i++)
			samples.push_back(randomPart());
	endtask

	initial begin
		void'($urandom(32'h7a1c));
		rstN = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		dataIn = '0;
		dataValid = 1'b0;
		dataLast = 1'b0;
		repeat (16) @(posedge clock);
		rstN <= 1'b1;
		@(negedge clock);
		assert (!mfValid && mfOutRe == 0 && mfOutIm == 0) else begin
			$display("Outputs were not idle after reset.");
			errors++;
		end
		apbAccess(1'b0, StatusAddr, 32'd0, rd, err);
		checkValue("status", rd, 32'd0);

		// Error responses for an unmapped address and a read-only register.
		apbAccess(1'b0, 32'h0C, 32'd0, rd, err);
		checkValue("pslverr", {31'd0, err}, 32'd1);
		apbAccess(1'b1, StatusAddr, 32'h7, rd, err);
		checkValue("pslverr", {31'd0, err}, 32'd1);

		// Impulse through a unit tap 0 shows the raw Hilbert output.
		for (int k = 0; k < FirTaps; k++) begin
			coefRe[k] = 0;
			coefIm[k] = 0;
		end
		coefRe[0] = 1;
		writeCoeffs();
		samples = '{512};
		buildExpected(samples.size() + HtDelay);
		apbAccess(1'b1, CtrlAddr, 32'h1, rd, err);
		sendSamples(1'b0, 1'b1);
		waitDone(4);

		// Samples offered while idle must not reach the output.
		samples = '{100, -200, 300};
		sendSamples(1'b0, 1'b0);
		repeat (4) @(posedge clock);

		// Random taps and stream, with a coefficient write rejected during the run.
		for (int k = 0; k < FirTaps; k++) begin
			coefRe[k] = randomPart();
			coefIm[k] = randomPart();
		end
		writeCoeffs();
		randomSamples(60);
		buildExpected(samples.size() + HtDelay);
		apbAccess(1'b1, CtrlAddr, 32'h1, rd, err);
		apbAccess(1'b1, CoeffBase, 32'h0123_0456, rd, err);
		checkValue("pslverr", {31'd0, err}, 32'd1);
		apbAccess(1'b0, CoeffBase, 32'd0, rd, err);
		checkValue("coefficient readback", rd, packCoeff(0));
		sendSamples(1'b1, 1'b1);
		waitDone(63);

		// Abort while samples are still in the pipeline. The rest of the stream
		// then meets an idle controller.
		randomSamples(20);
		buildExpected(samples.size());
		apbAccess(1'b1, CtrlAddr, 32'h1, rd, err);
		fork
			sendSamples(1'b0, 1'b0);
			begin
				repeat (10) @(posedge clock);
				apbAccess(1'b1, CtrlAddr, 32'h2, rd, err);
				// Results still in flight at the abort never appear.
				expRe.delete();
				expIm.delete();
			end
		join
		apbAccess(1'b0, StatusAddr, 32'd0, rd, err);
		checkValue("status after abort", rd, 32'd0);

		// A fresh run starts from a cleared pipeline.
		randomSamples(30);
		buildExpected(samples.size() + HtDelay);
		apbAccess(1'b1, CtrlAddr, 32'h1, rd, err);
		sendSamples(1'b1, 1'b1);
		waitDone(33);

		repeat (4) @(posedge clock);
		errors += matchedFilter_i.matchedFilterAsserts_i.failCount;
		$display("Outputs checked: %0d, errors: %0d", outputs, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: src.f
rtl/mfPkg.sv
rtl/sampleIf.sv
rtl/mfControl.sv
rtl/hilbertTransform.sv
rtl/complexFir.sv
rtl/matchedFilter.sv
dv/matchedFilter_asserts.sv
dv/matchedFilterTb.sv

// File: Makefile
# Verilator build and run for the matched filter testbench.
SOURCES := $(shell cat src.f)

obj_dir/VmatchedFilterTb: src.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module matchedFilterTb \
		-f src.f -o VmatchedFilterTb

.PHONY: run clean

run: obj_dir/VmatchedFilterTb
	@out="$$(./obj_dir/VmatchedFilterTb +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST RESULT: PASS$$'

clean:
	rm -rf obj_dir
